// File: design/fetchPkg.sv
// ********************************************************
// Fetch front end definitions
// Widths, PC and fetch-group types, redirect and BTB types,
// and the I-cache line-boundary check
// ********************************************************

package fetchPkg;

    localparam int FETCH_WIDTH = 2;
    localparam int INSN_BYTES = 4;
    localparam int INSN_OFFSET_BITS = $clog2(INSN_BYTES);
    localparam int LINE_BYTES = 16;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int PC_WIDTH = 32;
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_BITS = PC_WIDTH - BTB_INDEX_BITS - INSN_OFFSET_BITS;
    localparam int SERIAL_WIDTH = 16;

    typedef logic [PC_WIDTH-1:0] pcT;
    typedef logic [SERIAL_WIDTH-1:0] serialT;

    localparam pcT RESET_PC = 32'h0000_1000;

    // One instruction slot of a fetch group
    typedef struct packed {
        logic   valid;
        pcT     pc;
        serialT serial;
    } laneT;

    typedef laneT [FETCH_WIDTH-1:0] fetchGroupT;

    typedef struct packed {
        logic valid;
        pcT   target;
    } redirectT;

    typedef struct packed {
        logic we;
        pcT   pc;
        pcT   target;
        logic taken;
    } btbUpdateT;

    // Per-lane lookup result with bit i for lane i
    typedef struct packed {
        logic [FETCH_WIDTH-1:0] hit;
        logic [FETCH_WIDTH-1:0] taken;
        pcT   [FETCH_WIDTH-1:0] target;
    } btbResultT;

    typedef enum logic [1:0] {
        pcSrcCommit,
        pcSrcRename,
        pcSrcBtb,
        pcSrcSequential
    } pcSourceE;

    // True when the two addresses sit in different I-cache lines
    function automatic logic crossesLine(pcT pcA, pcT pcB);
        return pcA[LINE_OFFSET_BITS] != pcB[LINE_OFFSET_BITS];
    endfunction

endpackage

// File: design/branchTargetBuffer.sv
// ********************************************************
// Branch target buffer
// Direct-mapped, one registered read port per fetch lane,
// one write port for branch updates
// ********************************************************

`timescale 1ns/100ps

module branchTargetBuffer (
    input  logic                 clk,
    input  logic                 arstN,
    input  fetchPkg::pcT         readPc,
    input  fetchPkg::btbUpdateT  update,
    output fetchPkg::btbResultT  result
);
    import fetchPkg::*;

    // Entry storage
    logic [BTB_ENTRIES-1:0]  entryValid;
    logic [BTB_TAG_BITS-1:0] entryTag [BTB_ENTRIES];
    pcT                      entryTarget [BTB_ENTRIES];
    logic                    entryTaken [BTB_ENTRIES];

    // Read side
    pcT                        lanePc [FETCH_WIDTH];
    logic [BTB_INDEX_BITS-1:0] readIndex [FETCH_WIDTH];
    logic [BTB_TAG_BITS-1:0]   readTag [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0]    hitComb;

    // Registered outputs
    logic [FETCH_WIDTH-1:0]    hitQ;
    logic [FETCH_WIDTH-1:0]    takenQ;
    pcT   [FETCH_WIDTH-1:0]    targetQ;

    // Write side
    logic [BTB_INDEX_BITS-1:0] updateIndex;
    logic [BTB_TAG_BITS-1:0]   updateTag;

    assign updateIndex = update.pc[INSN_OFFSET_BITS +: BTB_INDEX_BITS];
    assign updateTag   = update.pc[PC_WIDTH-1 -: BTB_TAG_BITS];

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lanePc[i]    = readPc + pcT'(i * INSN_BYTES);
            readIndex[i] = lanePc[i][INSN_OFFSET_BITS +: BTB_INDEX_BITS];
            readTag[i]   = lanePc[i][PC_WIDTH-1 -: BTB_TAG_BITS];
            hitComb[i]   = entryValid[readIndex[i]] &&
                           (entryTag[readIndex[i]] == readTag[i]);
        end
    end

    // An update marks its entry valid
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
        end else if (update.we) begin
            entryValid[updateIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.we) begin
            entryTag[updateIndex]    <= updateTag;
            entryTarget[updateIndex] <= update.target;
            entryTaken[updateIndex]  <= update.taken;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hitQ <= '0;
        end else begin
            hitQ <= hitComb;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            takenQ[i]  <= entryTaken[readIndex[i]];
            targetQ[i] <= entryTarget[readIndex[i]];
        end
    end

    assign result.hit    = hitQ;
    assign result.taken  = takenQ;
    assign result.target = targetQ;

    // Branches are always instruction aligned
    updateAligned: assert property (@(posedge clk) disable iff (!arstN)
        update.we |-> (update.pc[INSN_OFFSET_BITS-1:0] == '0))
        else $error("BTB update at unaligned pc %h", update.pc);

endmodule

// File: design/nextPcStage.sv
// ********************************************************
// Next-PC stage
// Chooses the fetch address, builds the next fetch group,
// keeps the PC register, serial ids and I-cache address
// ********************************************************

`timescale 1ns/100ps

module nextPcStage (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 clear,
    input  fetchPkg::redirectT   commitRedirect,
    input  fetchPkg::redirectT   renameRedirect,
    input  logic                 interruptWe,
    input  fetchPkg::pcT         interruptAddr,
    input  fetchPkg::fetchGroupT fetchGroup,
    input  fetchPkg::btbResultT  btbResult,
    output fetchPkg::pcT         predNextPc,
    output fetchPkg::fetchGroupT nextGroup,
    output fetchPkg::pcT         icReadAddr,
    output fetchPkg::pcSourceE   pcSource
);
    import fetchPkg::*;

    pcT     pcReg;
    pcT     pcNext;
    logic   pcWe;
    logic   regStall;
    logic   beginStall;
    logic   btbSteer;
    pcT     btbNextPc;
    logic   lineCut;
    serialT serialReg;
    serialT serialNext;
    logic   leading;
    logic [$clog2(FETCH_WIDTH+1)-1:0] numValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regStall <= 1'b0;
        end else begin
            regStall <= stall;
        end
    end

    assign beginStall = !regStall && stall;

    // First valid lane in the fetch stage that hits the BTB steers fetch
    always_comb begin
        btbSteer  = 1'b0;
        btbNextPc = pcReg;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!btbSteer && !regStall && fetchGroup[i].valid && btbResult.hit[i]) begin
                btbSteer  = 1'b1;
                btbNextPc = btbResult.taken[i] ? btbResult.target[i]
                                               : fetchGroup[i].pc + pcT'(INSN_BYTES);
            end
        end
    end

    always_comb begin
        if (commitRedirect.valid) begin
            pcSource   = pcSrcCommit;
            predNextPc = commitRedirect.target;
        end else if (renameRedirect.valid) begin
            pcSource   = pcSrcRename;
            predNextPc = renameRedirect.target;
        end else if (btbSteer) begin
            pcSource   = pcSrcBtb;
            predNextPc = btbNextPc;
        end else begin
            pcSource   = pcSrcSequential;
            predNextPc = pcReg;
        end
    end

    // PC keeps moving on the first stall cycle so the held group resumes correctly
    assign pcWe = commitRedirect.valid || renameRedirect.valid || interruptWe ||
                  btbSteer || !stall || beginStall;

    always_comb begin
        lineCut = 1'b0;
        if (interruptWe) begin
            // Interrupt vector goes to the PC first, not through prediction
            pcNext = interruptAddr;
        end else if (beginStall) begin
            pcNext = predNextPc;
        end else begin
            pcNext = predNextPc + pcT'(FETCH_WIDTH * INSN_BYTES);
            for (int i = 1; i < FETCH_WIDTH; i++) begin
                if (!lineCut && crossesLine(predNextPc, predNextPc + pcT'(i * INSN_BYTES))) begin
                    // Stop the group at the line boundary
                    lineCut = 1'b1;
                    pcNext  = predNextPc + pcT'(i * INSN_BYTES);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= RESET_PC;
        end else if (pcWe) begin
            pcReg <= pcNext;
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            nextGroup[i].pc     = predNextPc + pcT'(i * INSN_BYTES);
            nextGroup[i].serial = serialReg + serialT'(i);
            nextGroup[i].valid  = !(interruptWe || clear ||
                                    crossesLine(predNextPc, nextGroup[i].pc));
        end
    end

    // Count leading valid lanes for the serial id
    always_comb begin
        numValid = '0;
        leading  = 1'b1;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (leading && nextGroup[i].valid) begin
                numValid = numValid + 1'b1;
            end else begin
                leading = 1'b0;
            end
        end
        serialNext = (stall || clear) ? serialReg : serialReg + serialT'(numValid);
    end

    // Serial ids start at 1
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            serialReg <= serialT'(1);
        end else begin
            serialReg <= serialNext;
        end
    end

    // Refetch the held fetch-stage line while stalled
    assign icReadAddr = (stall && fetchGroup[0].valid) ? fetchGroup[0].pc : predNextPc;

    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        pcReg[INSN_OFFSET_BITS-1:0] == '0)
        else $error("PC register unaligned: %h", pcReg);

    redirectsExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(commitRedirect.valid && renameRedirect.valid))
        else $warning("commit and rename redirects both valid, commit target used");

endmodule

// File: design/fetchStage.sv
// ********************************************************
// Fetch pipeline register
// Holds the fetch group under stall, drops it on clear,
// and masks BTB hits on lanes that carry no instruction
// ********************************************************

`timescale 1ns/100ps

module fetchStage (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 clear,
    input  fetchPkg::fetchGroupT nextGroup,
    input  fetchPkg::btbResultT  btbIn,
    output fetchPkg::fetchGroupT fetchGroup,
    output fetchPkg::btbResultT  btbResult
);
    import fetchPkg::*;

    logic [FETCH_WIDTH-1:0] validQ;
    pcT                     pcQ [FETCH_WIDTH];
    serialT                 serialQ [FETCH_WIDTH];

    // Clear has priority over stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= '0;
        end else if (clear) begin
            validQ <= '0;
        end else if (!stall) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                validQ[i] <= nextGroup[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                pcQ[i]     <= nextGroup[i].pc;
                serialQ[i] <= nextGroup[i].serial;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            fetchGroup[i].valid  = validQ[i];
            fetchGroup[i].pc     = pcQ[i];
            fetchGroup[i].serial = serialQ[i];
        end
    end

    // BTB output is already registered and lines up with this group
    assign btbResult.hit    = btbIn.hit & validQ;
    assign btbResult.taken  = btbIn.taken;
    assign btbResult.target = btbIn.target;

endmodule

// File: design/fetchFront.sv
// ********************************************************
// Fetch front end top
// Next-PC stage, branch target buffer and fetch register
// ********************************************************

`timescale 1ns/100ps

module fetchFront (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  logic                 clear,
    input  fetchPkg::redirectT   commitRedirect,
    input  fetchPkg::redirectT   renameRedirect,
    input  logic                 interruptWe,
    input  fetchPkg::pcT         interruptAddr,
    input  fetchPkg::btbUpdateT  btbUpdate,
    output fetchPkg::fetchGroupT fetchGroup,
    output fetchPkg::pcT         icReadAddr,
    output fetchPkg::pcSourceE   pcSource
);
    import fetchPkg::*;

    pcT         predNextPc;
    fetchGroupT nextGroup;
    btbResultT  btbRaw;
    btbResultT  btbResult;

    nextPcStage nextPcStage_inst (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .clear          (clear),
        .commitRedirect (commitRedirect),
        .renameRedirect (renameRedirect),
        .interruptWe    (interruptWe),
        .interruptAddr  (interruptAddr),
        .fetchGroup     (fetchGroup),
        .btbResult      (btbResult),
        .predNextPc     (predNextPc),
        .nextGroup      (nextGroup),
        .icReadAddr     (icReadAddr),
        .pcSource       (pcSource)
    );

    // Looked up with the address of the group being formed
    branchTargetBuffer branchTargetBuffer_inst (
        .clk    (clk),
        .arstN  (arstN),
        .readPc (predNextPc),
        .update (btbUpdate),
        .result (btbRaw)
    );

    fetchStage fetchStage_inst (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .clear      (clear),
        .nextGroup  (nextGroup),
        .btbIn      (btbRaw),
        .fetchGroup (fetchGroup),
        .btbResult  (btbResult)
    );

endmodule

// File: test/fetchFrontTb.sv
// ********************************************************
// Fetch front end testbench
// Table-driven stimulus with per-cycle checks of the fetch
// group, the chosen PC source and the I-cache read address
// ********************************************************

`timescale 1ns/100ps

module fetchFrontTb;
    import fetchPkg::*;

    localparam int NUM_ROWS = 20;
    localparam int TIMEOUT_CYCLES = 12 * NUM_ROWS;
    localparam int DRIVE_DELAY = 1;
    localparam int SETTLE_DELAY = 2;

    typedef enum logic [2:0] {
        opStep,
        opStall,
        opClear,
        opRedirectCommit,
        opRedirectRename,
        opBothRedirects,
        opInterrupt,
        opBtbWrite
    } opE;

    // addrA and addrB carry the operands of the operation
    typedef struct packed {
        opE                     op;
        pcT                     addrA;
        pcT                     addrB;
        logic                   taken;
        pcT                     expPc;
        logic [FETCH_WIDTH-1:0] expMask;
        serialT                 expSerial;
        pcSourceE               expSource;
    } rowT;

    logic       clk;
    logic       arstN;
    logic       stall;
    logic       clear;
    redirectT   commitRedirect;
    redirectT   renameRedirect;
    logic       interruptWe;
    pcT         interruptAddr;
    btbUpdateT  btbUpdate;
    fetchGroupT fetchGroup;
    pcT         icReadAddr;
    pcSourceE   pcSource;

    rowT   rows [NUM_ROWS];
    string rowNames [NUM_ROWS];
    int    rowCount;
    int    testErrors;
    int    passCount;
    int    failCount;
    int    cycleCount;

    fetchFront fetchFront_inst (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .clear          (clear),
        .commitRedirect (commitRedirect),
        .renameRedirect (renameRedirect),
        .interruptWe    (interruptWe),
        .interruptAddr  (interruptAddr),
        .btbUpdate      (btbUpdate),
        .fetchGroup     (fetchGroup),
        .icReadAddr     (icReadAddr),
        .pcSource       (pcSource)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the test table never finished", cycleCount);
        $display("Result: FAILED");
        $finish;
    end

    // Lanes stay valid while they still fit in the line of the start PC
    function automatic logic [FETCH_WIDTH-1:0] fetchMask(pcT startPc);
        logic [FETCH_WIDTH-1:0] mask;
        int                     lineOffset;
        lineOffset = int'(startPc % LINE_BYTES);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            mask[i] = (lineOffset + i * INSN_BYTES) < LINE_BYTES;
        end
        return mask;
    endfunction

    function automatic fetchGroupT expectedGroup(pcT startPc, logic [FETCH_WIDTH-1:0] mask,
                                                 serialT serial);
        fetchGroupT group;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            group[i].valid  = mask[i];
            group[i].pc     = startPc + pcT'(i * INSN_BYTES);
            group[i].serial = serial + serialT'(i);
        end
        return group;
    endfunction

    task automatic addRow(string name, opE op, pcT addrA, pcT addrB, logic taken,
                          pcT expPc, logic [FETCH_WIDTH-1:0] expMask, serialT expSerial,
                          pcSourceE expSource);
        rowNames[rowCount]       = name;
        rows[rowCount].op        = op;
        rows[rowCount].addrA     = addrA;
        rows[rowCount].addrB     = addrB;
        rows[rowCount].taken     = taken;
        rows[rowCount].expPc     = expPc;
        rows[rowCount].expMask   = expMask;
        rows[rowCount].expSerial = expSerial;
        rows[rowCount].expSource = expSource;
        rowCount++;
    endtask

    task automatic setIdle();
        stall          = 1'b0;
        clear          = 1'b0;
        commitRedirect = '0;
        renameRedirect = '0;
        interruptWe    = 1'b0;
        interruptAddr  = '0;
        btbUpdate      = '0;
    endtask

    task automatic applyOp(rowT row);
        setIdle();
        case (row.op)
            opStall:          stall = 1'b1;
            opClear:          clear = 1'b1;
            opRedirectCommit: commitRedirect = {1'b1, row.addrA};
            opRedirectRename: renameRedirect = {1'b1, row.addrA};
            opBothRedirects: begin
                commitRedirect = {1'b1, row.addrA};
                renameRedirect = {1'b1, row.addrB};
            end
            opInterrupt: begin
                interruptWe   = 1'b1;
                interruptAddr = row.addrA;
            end
            opBtbWrite:       btbUpdate = {1'b1, row.addrA, row.addrB, row.taken};
            default:          ;
        endcase
    endtask

    // Only valid lanes carry a defined PC and serial id
    task automatic checkGroup(string name, fetchGroupT expected, fetchGroupT actual);
        logic mismatch;
        mismatch = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (actual[i].valid !== expected[i].valid) begin
                mismatch = 1'b1;
            end else if (expected[i].valid && (actual[i].pc !== expected[i].pc ||
                         actual[i].serial !== expected[i].serial)) begin
                mismatch = 1'b1;
            end
        end
        if (mismatch) begin
            $display("CHECK FAILED %s: group expected %h, actual %h", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkPc(string name, pcT expected, pcT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: pc expected %h, actual %h", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkSource(string name, pcSourceE expected, pcSourceE actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: source expected %s, actual %s",
                     name, expected.name(), actual.name());
            testErrors++;
        end
    endtask

    task automatic reportTest(string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %s ok", name);
        end else begin
            failCount++;
            $display("test %s failed with %0d wrong check(s)", name, testErrors);
        end
    endtask

    task automatic buildTable();
        addRow("resetPcGroup", opStep, '0, '0, 1'b0,
               RESET_PC, fetchMask(RESET_PC), 1, pcSrcSequential);
        addRow("sequential", opStep, '0, '0, 1'b0,
               32'h1008, fetchMask(32'h1008), 3, pcSrcSequential);
        // Offset 12 leaves room for one instruction in the line
        addRow("commitRedirect", opRedirectCommit, 32'h200C, '0, 1'b0,
               32'h200C, fetchMask(32'h200C), 5, pcSrcCommit);
        addRow("lineBoundary", opStep, '0, '0, 1'b0,
               32'h2010, fetchMask(32'h2010), 6, pcSrcSequential);
        addRow("renameRedirect", opRedirectRename, 32'h3000, '0, 1'b0,
               32'h3000, fetchMask(32'h3000), 8, pcSrcRename);
        addRow("bothRedirects", opBothRedirects, 32'h4000, 32'h5000, 1'b0,
               32'h4000, fetchMask(32'h4000), 10, pcSrcCommit);
        addRow("btbWriteTaken", opBtbWrite, 32'h4010, 32'h6000, 1'b1,
               32'h4008, fetchMask(32'h4008), 12, pcSrcSequential);
        addRow("fetchBranch", opStep, '0, '0, 1'b0,
               32'h4010, fetchMask(32'h4010), 14, pcSrcSequential);
        addRow("btbTakenTarget", opStep, '0, '0, 1'b0,
               32'h6000, fetchMask(32'h6000), 16, pcSrcBtb);
        addRow("btbWriteNotTaken", opBtbWrite, 32'h4010, 32'h6000, 1'b0,
               32'h6008, fetchMask(32'h6008), 18, pcSrcSequential);
        addRow("refetchBranch", opRedirectCommit, 32'h4010, '0, 1'b0,
               32'h4010, fetchMask(32'h4010), 20, pcSrcCommit);
        addRow("btbNotTaken", opStep, '0, '0, 1'b0,
               32'h4014, fetchMask(32'h4014), 22, pcSrcBtb);
        // Lanes of a dropped group carry no PC, so expPc is only the I-cache address
        addRow("interrupt", opInterrupt, 32'h8000, '0, 1'b0,
               32'h401C, '0, 24, pcSrcSequential);
        addRow("interruptTarget", opStep, '0, '0, 1'b0,
               32'h8000, fetchMask(32'h8000), 24, pcSrcSequential);
        addRow("stallFirst", opStall, '0, '0, 1'b0,
               32'h8000, fetchMask(32'h8000), 24, pcSrcSequential);
        addRow("stallHold", opStall, '0, '0, 1'b0,
               32'h8000, fetchMask(32'h8000), 24, pcSrcSequential);
        addRow("stallHoldAgain", opStall, '0, '0, 1'b0,
               32'h8000, fetchMask(32'h8000), 24, pcSrcSequential);
        addRow("stallRelease", opStep, '0, '0, 1'b0,
               32'h8008, fetchMask(32'h8008), 26, pcSrcSequential);
        addRow("clear", opClear, '0, '0, 1'b0,
               32'h8010, '0, 28, pcSrcSequential);
        addRow("afterClear", opStep, '0, '0, 1'b0,
               32'h8018, fetchMask(32'h8018), 28, pcSrcSequential);
    endtask

    initial begin
        rowCount   = 0;
        passCount  = 0;
        failCount  = 0;
        testErrors = 0;
        arstN      = 1'b0;
        setIdle();
        buildTable();
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        arstN = 1'b1;

        // Fetch register comes out of reset empty
        checkGroup("afterReset", expectedGroup(RESET_PC, '0, 1), fetchGroup);
        reportTest("afterReset");

        for (int r = 0; r < rowCount; r++) begin
            testErrors = 0;
            applyOp(rows[r]);
            #(SETTLE_DELAY);
            checkSource(rowNames[r], rows[r].expSource, pcSource);
            // I-cache reads the new fetch address, or the held lane 0 while stalled
            checkPc(rowNames[r], rows[r].expPc, icReadAddr);
            @(posedge clk);
            #(DRIVE_DELAY);
            checkGroup(rowNames[r],
                       expectedGroup(rows[r].expPc, rows[r].expMask, rows[r].expSerial),
                       fetchGroup);
            reportTest(rowNames[r]);
        end

        $display("Tests run: %0d, ok: %0d, failing: %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
design/fetchPkg.sv
design/branchTargetBuffer.sv
design/nextPcStage.sv
design/fetchStage.sv
design/fetchFront.sv
test/fetchFrontTb.sv
